// File: rtl/mdu_pkg.sv
package mdu_pkg;

	// ----------------------------------------------------------------------
	// tag widths carried through the MDU
	// ----------------------------------------------------------------------

	// physical register tag, 128 registers
	localparam int PR_TAG_BITS = 7;
	// ROB index, 64 entries
	localparam int ROB_TAG_BITS = 6;

	// result buffer entries, also the internal credit pool
	localparam int WB_BUF_DEPTH = 4;
	localparam int LOG_WB_BUF_DEPTH = $clog2(WB_BUF_DEPTH);

	// occupancy / credit counters, 0..WB_BUF_DEPTH
	typedef logic [LOG_WB_BUF_DEPTH:0] wb_cnt_t;

	// RV32M funct3 order
	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} mdu_op_e;

	// operand stage -> execute units
	typedef struct packed {
		mdu_op_e op;
		logic [31:0] a;
		logic [31:0] b;
		logic [PR_TAG_BITS-1:0] dest_pr;
		logic [ROB_TAG_BITS-1:0] rob_index;
	} mdu_exec_t;

	// iterative divider FSM
	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		DONE
	} div_state_e;

endpackage

// File: rtl/core_types_pkg.sv
package core_types_pkg;

	// ----------------------------------------------------------------------
	// core-wide sizing
	// ----------------------------------------------------------------------

	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;
	// tag widths follow the MDU exec path
	localparam int LOG_PR_COUNT = mdu_pkg::PR_TAG_BITS;
	localparam int LOG_ROB_ENTRIES = mdu_pkg::ROB_TAG_BITS;

	// IQ credits toward the MDU after reset
	localparam int ISSUE_CREDITS = 1;

	// issued micro-op, operand sources per side
	typedef struct packed {
		mdu_pkg::mdu_op_e op;
		logic a_forward;
		logic a_is_zero;
		logic [LOG_PRF_BANK_COUNT-1:0] a_bank;
		logic b_forward;
		logic b_is_zero;
		logic [LOG_PRF_BANK_COUNT-1:0] b_bank;
		logic [LOG_PR_COUNT-1:0] dest_pr;
		logic [LOG_ROB_ENTRIES-1:0] rob_index;
	} issue_pkt_t;

	// writeback to PRF and ROB
	typedef struct packed {
		logic [31:0] data;
		logic [LOG_PR_COUNT-1:0] pr;
		logic [LOG_ROB_ENTRIES-1:0] rob_index;
	} wb_pkt_t;

endpackage

// File: rtl/mdu_operand_collect.sv
module mdu_operand_collect (
	input logic CLK,
	input logic nRST,

	// issue from IQ
	input logic issue_valid,
	input core_types_pkg::issue_pkt_t issue,
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0] forward_data_by_bank,

	// late operand reads from PRF
	input logic a_reg_read_ack,
	input logic a_reg_read_port,
	input logic b_reg_read_ack,
	input logic b_reg_read_port,
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port,

	// downstream availability
	input logic [2:0] free_slots,
	input logic div_idle,

	// to execute units
	output logic exec_valid,
	output mdu_pkg::mdu_exec_t exec,
	output logic issue_credit
);
	import core_types_pkg::*;
	import mdu_pkg::*;

	// single held micro-op
	logic held;
	issue_pkt_t held_pkt;
	logic a_have;
	logic b_have;
	logic [31:0] a_data;
	logic [31:0] b_data;

	// dispatch qualifiers
	logic is_div;
	logic unit_free;
	logic a_late;
	logic b_late;

	// issue-cycle operand: zero or forward bus
	function automatic logic [31:0] issue_operand(
		input logic is_zero,
		input logic [LOG_PRF_BANK_COUNT-1:0] bank,
		input logic [PRF_BANK_COUNT-1:0][31:0] fwd
	);
		issue_operand = is_zero ? 32'h0 : fwd[bank];
	endfunction

	// ----------------------------------------------------------------------
	// dispatch
	// ----------------------------------------------------------------------

	assign is_div = held_pkt.op inside {DIV, DIVU, REM, REMU};
	// multiplier always accepts, divider only when idle
	assign unit_free = !is_div || div_idle;
	assign exec_valid = held && a_have && b_have && (free_slots != 3'd0) && unit_free;
	// credit goes back as the op leaves
	assign issue_credit = exec_valid;

	assign exec.op = held_pkt.op;
	assign exec.a = a_data;
	assign exec.b = b_data;
	assign exec.dest_pr = held_pkt.dest_pr;
	assign exec.rob_index = held_pkt.rob_index;

	// acks only count while waiting on that side
	assign a_late = held && !a_have && a_reg_read_ack;
	assign b_late = held && !b_have && b_reg_read_ack;

	// ----------------------------------------------------------------------
	// hold state
	// ----------------------------------------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			held <= 1'b0;
			a_have <= 1'b0;
			b_have <= 1'b0;
		end else if (issue_valid) begin
			held <= 1'b1;
			a_have <= issue.a_is_zero || issue.a_forward;
			b_have <= issue.b_is_zero || issue.b_forward;
		end else if (exec_valid) begin
			held <= 1'b0;
			a_have <= 1'b0;
			b_have <= 1'b0;
		end else begin
			if (a_late)
				a_have <= 1'b1;
			if (b_late)
				b_have <= 1'b1;
		end
	end

	// operand payload
	always_ff @(posedge CLK) begin
		if (issue_valid) begin
			held_pkt <= issue;
			a_data <= issue_operand(issue.a_is_zero, issue.a_bank, forward_data_by_bank);
			b_data <= issue_operand(issue.b_is_zero, issue.b_bank, forward_data_by_bank);
		end else begin
			// bank read lands at stored bank, acked port
			if (a_late)
				a_data <= reg_read_data_by_bank_by_port[held_pkt.a_bank][a_reg_read_port];
			if (b_late)
				b_data <= reg_read_data_by_bank_by_port[held_pkt.b_bank][b_reg_read_port];
		end
	end

endmodule

// File: rtl/mdu_multiplier.sv
module mdu_multiplier (
	input logic CLK,
	input logic nRST,

	// from operand stage
	input logic exec_valid,
	input mdu_pkg::mdu_exec_t exec,

	// result to writeback
	output logic mul_valid,
	output core_types_pkg::wb_pkt_t mul_result
);
	import core_types_pkg::*;
	import mdu_pkg::*;

	logic is_mul;
	logic a_signed;
	logic b_signed;
	logic signed [32:0] a_ext;
	logic signed [32:0] b_ext;
	logic signed [65:0] product;

	// stage one regs
	logic s1_valid;
	mdu_op_e s1_op;
	logic [63:0] s1_prod;
	logic [LOG_PR_COUNT-1:0] s1_pr;
	logic [LOG_ROB_ENTRIES-1:0] s1_rob;

	// ----------------------------------------------------------------------
	// stage one, 33x33 signed product
	// ----------------------------------------------------------------------

	assign is_mul = exec.op inside {MUL, MULH, MULHSU, MULHU};
	// MULHSU: a signed, b unsigned
	assign a_signed = exec.op inside {MULH, MULHSU};
	assign b_signed = exec.op == MULH;
	assign a_ext = {a_signed & exec.a[31], exec.a};
	assign b_ext = {b_signed & exec.b[31], exec.b};
	assign product = a_ext * b_ext;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			s1_valid <= 1'b0;
			mul_valid <= 1'b0;
		end else begin
			// divides never show up here
			s1_valid <= exec_valid && is_mul;
			mul_valid <= s1_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exec_valid) begin
			s1_op <= exec.op;
			s1_prod <= product[63:0];
			s1_pr <= exec.dest_pr;
			s1_rob <= exec.rob_index;
		end
		// stage two, word select
		mul_result.data <= (s1_op == MUL) ? s1_prod[31:0] : s1_prod[63:32];
		mul_result.pr <= s1_pr;
		mul_result.rob_index <= s1_rob;
	end

endmodule

// File: rtl/mdu_divider.sv
module mdu_divider (
	input logic CLK,
	input logic nRST,

	// from operand stage
	input logic exec_valid,
	input mdu_pkg::mdu_exec_t exec,

	// status and result
	output logic div_idle,
	output logic div_valid,
	output core_types_pkg::wb_pkt_t div_result
);
	import core_types_pkg::*;
	import mdu_pkg::*;

	div_state_e state;
	logic [4:0] count;

	// iteration regs
	logic [31:0] quo;
	logic [31:0] rem;
	logic [31:0] divisor;
	logic neg_q;
	logic neg_r;
	logic want_rem;
	logic [LOG_PR_COUNT-1:0] pr;
	logic [LOG_ROB_ENTRIES-1:0] rob;

	// launch decode
	logic start;
	logic is_signed;
	logic a_neg;
	logic b_neg;
	logic div_zero;
	logic [31:0] a_mag;
	logic [31:0] b_mag;

	// restoring step
	logic [32:0] rem_shift;
	logic [32:0] diff;
	logic [31:0] quo_out;
	logic [31:0] rem_out;

	assign start = exec_valid && (exec.op inside {DIV, DIVU, REM, REMU});
	assign is_signed = exec.op inside {DIV, REM};
	assign a_neg = is_signed && exec.a[31];
	assign b_neg = is_signed && exec.b[31];
	assign a_mag = a_neg ? -exec.a : exec.a;
	assign b_mag = b_neg ? -exec.b : exec.b;
	assign div_zero = exec.b == 32'h0;

	// shift in next dividend bit, trial subtract
	assign rem_shift = {rem, quo[31]};
	assign diff = rem_shift - {1'b0, divisor};

	// ----------------------------------------------------------------------
	// FSM, 32 iterations then one result cycle
	// ----------------------------------------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			count <= 5'd0;
		end else begin
			case (state)
				IDLE: begin
					count <= 5'd0;
					// div by zero skips straight to result
					if (start)
						state <= div_zero ? DONE : BUSY;
				end
				BUSY: begin
					count <= count + 5'd1;
					if (count == 5'd31)
						state <= DONE;
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == IDLE && start) begin
			want_rem <= exec.op inside {REM, REMU};
			pr <= exec.dest_pr;
			rob <= exec.rob_index;
			divisor <= b_mag;
			if (div_zero) begin
				// quotient all ones, remainder is dividend
				quo <= '1;
				rem <= exec.a;
				neg_q <= 1'b0;
				neg_r <= 1'b0;
			end else begin
				quo <= a_mag;
				rem <= 32'h0;
				// min / -1 falls out as 0x80000000 rem 0
				neg_q <= a_neg ^ b_neg;
				neg_r <= a_neg;
			end
		end else if (state == BUSY) begin
			if (!diff[32]) begin
				rem <= diff[31:0];
				quo <= {quo[30:0], 1'b1};
			end else begin
				rem <= rem_shift[31:0];
				quo <= {quo[30:0], 1'b0};
			end
		end
	end

	// sign fix on the way out
	assign quo_out = neg_q ? -quo : quo;
	assign rem_out = neg_r ? -rem : rem;

	assign div_idle = state == IDLE;
	assign div_valid = state == DONE;
	assign div_result.data = want_rem ? rem_out : quo_out;
	assign div_result.pr = pr;
	assign div_result.rob_index = rob;

endmodule

// File: rtl/mdu_writeback.sv
module mdu_writeback (
	input logic CLK,
	input logic nRST,

	// execute results
	input logic mul_valid,
	input core_types_pkg::wb_pkt_t mul_result,
	input logic div_valid,
	input core_types_pkg::wb_pkt_t div_result,

	// dispatch reserves a slot
	input logic exec_valid,
	output logic [2:0] free_slots,

	// writeback, credit gated
	input logic wb_credit,
	output logic wb_valid,
	output core_types_pkg::wb_pkt_t wb
);
	import core_types_pkg::*;
	import mdu_pkg::*;

	// result FIFO, 2 write ports, 1 read port
	wb_pkt_t buffer [WB_BUF_DEPTH];
	logic [LOG_WB_BUF_DEPTH-1:0] wr_ptr;
	logic [LOG_WB_BUF_DEPTH-1:0] rd_ptr;
	logic [LOG_WB_BUF_DEPTH-1:0] mul_slot;

	wb_cnt_t count;
	wb_cnt_t inflight;
	wb_cnt_t credits;
	wb_cnt_t n_write;
	logic pop;

	assign n_write = wb_cnt_t'(mul_valid) + wb_cnt_t'(div_valid);
	// divider takes the first port on a tie
	assign mul_slot = div_valid ? wr_ptr + 1'b1 : wr_ptr;

	// occupied plus reserved never exceeds depth
	assign free_slots = wb_cnt_t'(WB_BUF_DEPTH) - count - inflight;

	// pop needs an entry and a consumer credit
	assign pop = (count != '0) && (credits != '0);
	assign wb_valid = pop;
	assign wb = buffer[rd_ptr];

	always_ff @(posedge CLK) begin
		if (div_valid)
			buffer[wr_ptr] <= div_result;
		if (mul_valid)
			buffer[mul_slot] <= mul_result;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			inflight <= '0;
			credits <= wb_cnt_t'(WB_BUF_DEPTH);
		end else begin
			wr_ptr <= wr_ptr + n_write[LOG_WB_BUF_DEPTH-1:0];
			rd_ptr <= rd_ptr + LOG_WB_BUF_DEPTH'(pop);
			count <= count + n_write - wb_cnt_t'(pop);
			// reservation released when the result lands
			inflight <= inflight + wb_cnt_t'(exec_valid) - n_write;
			credits <= credits + wb_cnt_t'(wb_credit) - wb_cnt_t'(pop);
		end
	end

endmodule

// File: rtl/mdu_pipeline.sv
module mdu_pipeline (
	input logic CLK,
	input logic nRST,

	// issue from IQ
	input logic issue_valid,
	input core_types_pkg::issue_pkt_t issue,
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0] forward_data_by_bank,
	output logic issue_credit,

	// late reads from PRF
	input logic a_reg_read_ack,
	input logic a_reg_read_port,
	input logic b_reg_read_ack,
	input logic b_reg_read_port,
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port,

	// writeback
	input logic wb_credit,
	output logic wb_valid,
	output core_types_pkg::wb_pkt_t wb
);
	import core_types_pkg::*;
	import mdu_pkg::*;

	// operand stage -> units
	logic exec_valid;
	mdu_exec_t exec;
	logic [2:0] free_slots;
	logic div_idle;

	// units -> writeback
	logic mul_valid;
	wb_pkt_t mul_result;
	logic div_valid;
	wb_pkt_t div_result;

	mdu_operand_collect u_operand_collect (
		.CLK(CLK),
		.nRST(nRST),
		.issue_valid(issue_valid),
		.issue(issue),
		.forward_data_by_bank(forward_data_by_bank),
		.a_reg_read_ack(a_reg_read_ack),
		.a_reg_read_port(a_reg_read_port),
		.b_reg_read_ack(b_reg_read_ack),
		.b_reg_read_port(b_reg_read_port),
		.reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
		.free_slots(free_slots),
		.div_idle(div_idle),
		.exec_valid(exec_valid),
		.exec(exec),
		.issue_credit(issue_credit)
	);

	mdu_multiplier u_multiplier (
		.CLK(CLK),
		.nRST(nRST),
		.exec_valid(exec_valid),
		.exec(exec),
		.mul_valid(mul_valid),
		.mul_result(mul_result)
	);

	mdu_divider u_divider (
		.CLK(CLK),
		.nRST(nRST),
		.exec_valid(exec_valid),
		.exec(exec),
		.div_idle(div_idle),
		.div_valid(div_valid),
		.div_result(div_result)
	);

	mdu_writeback u_writeback (
		.CLK(CLK),
		.nRST(nRST),
		.mul_valid(mul_valid),
		.mul_result(mul_result),
		.div_valid(div_valid),
		.div_result(div_result),
		.exec_valid(exec_valid),
		.free_slots(free_slots),
		.wb_credit(wb_credit),
		.wb_valid(wb_valid),
		.wb(wb)
	);

endmodule

// File: rtl/mdu_pipeline_wrapper.sv
module mdu_pipeline_wrapper (
	input logic CLK,
	input logic nRST,

	// issue from IQ
	input logic issue_valid,
	input core_types_pkg::issue_pkt_t issue,
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0] forward_data_by_bank,
	output logic issue_credit,

	// late reads from PRF
	input logic a_reg_read_ack,
	input logic a_reg_read_port,
	input logic b_reg_read_ack,
	input logic b_reg_read_port,
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port,

	// writeback
	input logic wb_credit,
	output logic wb_valid,
	output core_types_pkg::wb_pkt_t wb
);
	import core_types_pkg::*;

	// ----------------------------------------------------------------------
	// signals at the pipeline boundary
	// ----------------------------------------------------------------------

	logic pipe_issue_valid;
	issue_pkt_t pipe_issue;
	logic [PRF_BANK_COUNT-1:0][31:0] pipe_forward_data_by_bank;
	logic pipe_issue_credit;
	logic pipe_a_reg_read_ack;
	logic pipe_a_reg_read_port;
	logic pipe_b_reg_read_ack;
	logic pipe_b_reg_read_port;
	logic [PRF_BANK_COUNT-1:0][1:0][31:0] pipe_reg_read_data_by_bank_by_port;
	logic pipe_wb_credit;
	logic pipe_wb_valid;
	wb_pkt_t pipe_wb;

	mdu_pipeline u_mdu_pipeline (
		.CLK(CLK),
		.nRST(nRST),
		.issue_valid(pipe_issue_valid),
		.issue(pipe_issue),
		.forward_data_by_bank(pipe_forward_data_by_bank),
		.issue_credit(pipe_issue_credit),
		.a_reg_read_ack(pipe_a_reg_read_ack),
		.a_reg_read_port(pipe_a_reg_read_port),
		.b_reg_read_ack(pipe_b_reg_read_ack),
		.b_reg_read_port(pipe_b_reg_read_port),
		.reg_read_data_by_bank_by_port(pipe_reg_read_data_by_bank_by_port),
		.wb_credit(pipe_wb_credit),
		.wb_valid(pipe_wb_valid),
		.wb(pipe_wb)
	);

	// ----------------------------------------------------------------------
	// one register stage each way
	// ----------------------------------------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// inputs
			pipe_issue_valid <= 1'b0;
			pipe_issue <= '0;
			pipe_forward_data_by_bank <= '0;
			pipe_a_reg_read_ack <= 1'b0;
			pipe_a_reg_read_port <= 1'b0;
			pipe_b_reg_read_ack <= 1'b0;
			pipe_b_reg_read_port <= 1'b0;
			pipe_reg_read_data_by_bank_by_port <= '0;
			pipe_wb_credit <= 1'b0;
			// outputs
			issue_credit <= 1'b0;
			wb_valid <= 1'b0;
			wb <= '0;
		end else begin
			pipe_issue_valid <= issue_valid;
			pipe_issue <= issue;
			pipe_forward_data_by_bank <= forward_data_by_bank;
			pipe_a_reg_read_ack <= a_reg_read_ack;
			pipe_a_reg_read_port <= a_reg_read_port;
			pipe_b_reg_read_ack <= b_reg_read_ack;
			pipe_b_reg_read_port <= b_reg_read_port;
			pipe_reg_read_data_by_bank_by_port <= reg_read_data_by_bank_by_port;
			pipe_wb_credit <= wb_credit;
			issue_credit <= pipe_issue_credit;
			wb_valid <= pipe_wb_valid;
			wb <= pipe_wb;
		end
	end

endmodule

// File: dv/mdu_tb.sv
module mdu_tb;
	import core_types_pkg::*;
	import mdu_pkg::*;

	// where an operand comes from
	typedef enum int {
		SRC_ZERO,
		SRC_FWD,
		SRC_READ
	} src_e;

	logic CLK;
	logic nRST;
	logic issue_valid;
	issue_pkt_t issue;
	logic [PRF_BANK_COUNT-1:0][31:0] forward_data_by_bank;
	logic issue_credit;
	logic a_reg_read_ack;
	logic a_reg_read_port;
	logic b_reg_read_ack;
	logic b_reg_read_port;
	logic [PRF_BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port;
	logic wb_credit = 1'b0;
	logic wb_valid;
	wb_pkt_t wb;

	integer seed = 96;

	// issue queue and consumer bookkeeping
	int issued = 0;
	int credits_returned = 0;
	int wb_seen = 0;
	int wb_given = 0;
	bit credit_hold = 1'b0;

	// expectations by ROB index
	wb_pkt_t exp_wb [64];
	bit exp_pending [64];
	int expected_total = 0;
	int checked_total = 0;
	int next_rob = 0;
	int arrival [$];

	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	mdu_pipeline_wrapper u_mdu_pipeline_wrapper (
		.CLK(CLK),
		.nRST(nRST),
		.issue_valid(issue_valid),
		.issue(issue),
		.forward_data_by_bank(forward_data_by_bank),
		.issue_credit(issue_credit),
		.a_reg_read_ack(a_reg_read_ack),
		.a_reg_read_port(a_reg_read_port),
		.b_reg_read_ack(b_reg_read_ack),
		.b_reg_read_port(b_reg_read_port),
		.reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
		.wb_credit(wb_credit),
		.wb_valid(wb_valid),
		.wb(wb)
	);

	// ----------------------------------------------------------------------
	// reference model, RV32M rules
	// ----------------------------------------------------------------------

	function automatic logic [31:0] rv32m_result(
		input mdu_op_e op,
		input logic [31:0] a,
		input logic [31:0] b
	);
		longint sa;
		longint sb;
		longint ub_s;
		longint unsigned ua;
		longint unsigned ub;
		logic [63:0] p;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		ua = {32'h0, a};
		ub = {32'h0, b};
		ub_s = {32'h0, b};
		case (op)
			MUL: begin
				p = ua * ub;
				return p[31:0];
			end
			MULH: begin
				p = sa * sb;
				return p[63:32];
			end
			// signed times unsigned, fits in 64 bits
			MULHSU: begin
				p = sa * ub_s;
				return p[63:32];
			end
			MULHU: begin
				p = ua * ub;
				return p[63:32];
			end
			DIV: begin
				if (b == 32'h0)
					return 32'hffffffff;
				if (a == 32'h80000000 && b == 32'hffffffff)
					return a;
				p = sa / sb;
				return p[31:0];
			end
			DIVU: begin
				if (b == 32'h0)
					return 32'hffffffff;
				return a / b;
			end
			// remainder takes the dividend's sign
			REM: begin
				if (b == 32'h0)
					return a;
				if (a == 32'h80000000 && b == 32'hffffffff)
					return 32'h0;
				p = sa % sb;
				return p[31:0];
			end
			default: begin
				if (b == 32'h0)
					return a;
				return a % b;
			end
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------

	task automatic compare_wb(input wb_pkt_t got);
		int idx;
		idx = int'(got.rob_index);
		if (!exp_pending[idx]) begin
			$display("writeback at %0t for rob %0d was not expected or came twice", $time, idx);
			errors++;
		end else begin
			exp_pending[idx] = 1'b0;
			checked_total++;
			if (got.data !== exp_wb[idx].data) begin
				$display("error at %0t: wb.data rob %0d got %h expected %h",
					$time, idx, got.data, exp_wb[idx].data);
				errors++;
			end
			if (got.pr !== exp_wb[idx].pr) begin
				$display("error at %0t: wb.pr rob %0d got %0d expected %0d",
					$time, idx, got.pr, exp_wb[idx].pr);
				errors++;
			end
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// ----------------------------------------------------------------------
	// output monitor and writeback consumer
	// ----------------------------------------------------------------------

	always @(negedge CLK) begin
		if (nRST) begin
			if (issue_credit) begin
				credits_returned++;
				if (credits_returned > issued) begin
					$display("issue credit at %0t came back with no micro-op outstanding", $time);
					errors++;
				end
			end
			if (wb_valid) begin
				// consumer view of credits still held by the DUT
				if (wb_seen >= WB_BUF_DEPTH + wb_given) begin
					$display("wb_valid at %0t arrived without a writeback credit", $time);
					errors++;
				end
				wb_seen++;
				arrival.push_back(int'(wb.rob_index));
				compare_wb(wb);
			end
		end
		// one freed slot per cycle, unless held back
		if (nRST && !credit_hold && wb_given < wb_seen) begin
			wb_credit = 1'b1;
			wb_given++;
		end else begin
			wb_credit = 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// issue queue and register file models
	// ----------------------------------------------------------------------

	// junk everywhere so a wrong bank or port shows up
	task automatic scramble_buses();
		int i;
		int j;
		for (i = 0; i < PRF_BANK_COUNT; i++) begin
			forward_data_by_bank[i] = $random(seed);
			for (j = 0; j < 2; j++)
				reg_read_data_by_bank_by_port[i][j] = $random(seed);
		end
	endtask

	task automatic wait_issue_credit(input int limit, output bit ok);
		int t;
		ok = 1'b0;
		for (t = 0; t < limit; t++) begin
			@(posedge CLK);
			if (ISSUE_CREDITS + credits_returned - issued > 0) begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	function automatic bit drained();
		return checked_total == expected_total && wb_given == wb_seen;
	endfunction

	task automatic wait_until_idle(input int limit);
		int t;
		for (t = 0; t < limit; t++) begin
			@(posedge CLK);
			if (drained())
				break;
		end
		if (!drained()) begin
			$display("timed out after %0d cycles waiting for results and credits", limit);
			errors++;
		end
	endtask

	// bank read answered 1 to 4 cycles later on a random port
	task automatic answer_read(input bit side_b, input logic [1:0] bank, input logic [31:0] value);
		int d;
		logic port;
		d = 1 + ($random(seed) & 3);
		port = 1'($random(seed));
		repeat (d - 1) @(negedge CLK);
		scramble_buses();
		reg_read_data_by_bank_by_port[bank][port] = value;
		if (side_b) begin
			b_reg_read_ack = 1'b1;
			b_reg_read_port = port;
		end else begin
			a_reg_read_ack = 1'b1;
			a_reg_read_port = port;
		end
		@(negedge CLK);
		a_reg_read_ack = 1'b0;
		b_reg_read_ack = 1'b0;
	endtask

	task automatic issue_op(
		input mdu_op_e op,
		input src_e a_src,
		input src_e b_src,
		input logic [31:0] a_val,
		input logic [31:0] b_val
	);
		issue_pkt_t pkt;
		logic [31:0] a_eff;
		logic [31:0] b_eff;
		int rob;
		bit ok;
		wait_issue_credit(400, ok);
		if (!ok) begin
			$display("issue credit never came back before rob %0d at %0t", next_rob, $time);
			errors++;
			return;
		end
		rob = next_rob;
		next_rob = (next_rob + 1) % 64;
		a_eff = (a_src == SRC_ZERO) ? 32'h0 : a_val;
		b_eff = (b_src == SRC_ZERO) ? 32'h0 : b_val;
		pkt = '0;
		pkt.op = op;
		pkt.a_is_zero = a_src == SRC_ZERO;
		pkt.a_forward = a_src == SRC_FWD;
		pkt.a_bank = 2'(rob);
		pkt.b_is_zero = b_src == SRC_ZERO;
		pkt.b_forward = b_src == SRC_FWD;
		pkt.b_bank = 2'(rob + 1);
		pkt.dest_pr = 7'(rob + 64);
		pkt.rob_index = 6'(rob);
		if (exp_pending[rob]) begin
			$display("rob %0d reused while still in flight at %0t", rob, $time);
			errors++;
		end
		exp_wb[rob].data = rv32m_result(op, a_eff, b_eff);
		exp_wb[rob].pr = pkt.dest_pr;
		exp_wb[rob].rob_index = pkt.rob_index;
		exp_pending[rob] = 1'b1;
		expected_total++;
		@(negedge CLK);
		scramble_buses();
		if (a_src == SRC_FWD)
			forward_data_by_bank[pkt.a_bank] = a_val;
		if (b_src == SRC_FWD)
			forward_data_by_bank[pkt.b_bank] = b_val;
		issue = pkt;
		issue_valid = 1'b1;
		issued++;
		@(negedge CLK);
		issue_valid = 1'b0;
		if (a_src == SRC_READ)
			answer_read(1'b0, pkt.a_bank, a_val);
		if (b_src == SRC_READ)
			answer_read(1'b1, pkt.b_bank, b_val);
	endtask

	task automatic set_credit_hold(input bit hold);
		@(posedge CLK);
		credit_hold = hold;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("%s passed", name);
		end else begin
			tests_failed++;
			$display("%s failed with %0d errors", name, errors - errors_before);
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------

	task automatic test_mul_ops();
		int e0;
		e0 = errors;
		issue_op(MUL, SRC_FWD, SRC_FWD, 32'd123456, 32'hfffffff3);
		issue_op(MULH, SRC_READ, SRC_FWD, 32'h80000000, 32'h7fffffff);
		issue_op(MULHSU, SRC_FWD, SRC_READ, 32'hfffffffe, 32'hffffffff);
		issue_op(MULHU, SRC_READ, SRC_READ, 32'hffffffff, 32'hffffffff);
		issue_op(MUL, SRC_ZERO, SRC_FWD, 32'h12345678, 32'h9abcdef0);
		issue_op(MULH, SRC_FWD, SRC_ZERO, 32'hdeadbeef, 32'h12345678);
		issue_op(MULHSU, SRC_READ, SRC_READ, 32'h80000000, 32'h80000000);
		wait_until_idle(400);
		finish_test("test_mul_ops", e0);
	endtask

	task automatic test_div_ops();
		int e0;
		e0 = errors;
		issue_op(DIV, SRC_FWD, SRC_FWD, 32'hffffffec, 32'd3);
		issue_op(DIVU, SRC_READ, SRC_FWD, 32'hfffffff0, 32'd3);
		issue_op(REM, SRC_FWD, SRC_READ, 32'hffffffec, 32'd3);
		issue_op(REMU, SRC_READ, SRC_READ, 32'd100, 32'd7);
		issue_op(DIV, SRC_FWD, SRC_FWD, 32'd20, 32'hfffffffd);
		issue_op(REM, SRC_READ, SRC_FWD, 32'd20, 32'hfffffffd);
		// divide by zero
		issue_op(DIV, SRC_FWD, SRC_ZERO, 32'd1234, 32'd9);
		issue_op(DIVU, SRC_READ, SRC_FWD, 32'd5, 32'd0);
		issue_op(REM, SRC_FWD, SRC_ZERO, 32'hffffff00, 32'd1);
		issue_op(REMU, SRC_FWD, SRC_READ, 32'd77, 32'd0);
		// overflow case
		issue_op(DIV, SRC_FWD, SRC_FWD, 32'h80000000, 32'hffffffff);
		issue_op(REM, SRC_READ, SRC_READ, 32'h80000000, 32'hffffffff);
		wait_until_idle(800);
		finish_test("test_div_ops", e0);
	endtask

	task automatic test_operand_sources();
		int e0;
		int sa;
		int sb;
		e0 = errors;
		// same values through every nonzero source pairing
		for (sa = 1; sa <= 2; sa++) begin
			for (sb = 1; sb <= 2; sb++) begin
				issue_op(REM, src_e'(sa), src_e'(sb), 32'hffffff9c, 32'd7);
				issue_op(MULHSU, src_e'(sa), src_e'(sb), 32'h87654321, 32'hfedcba98);
			end
		end
		issue_op(MULH, SRC_ZERO, SRC_READ, 32'h55555555, 32'haaaaaaaa);
		issue_op(DIVU, SRC_READ, SRC_ZERO, 32'h0000f00d, 32'd3);
		wait_until_idle(800);
		finish_test("test_operand_sources", e0);
	endtask

	task automatic test_out_of_order();
		int e0;
		int div_rob;
		int k;
		e0 = errors;
		arrival.delete();
		div_rob = next_rob;
		issue_op(DIV, SRC_FWD, SRC_FWD, 32'hfff00000, 32'd7);
		for (k = 0; k < 3; k++)
			issue_op(MUL, SRC_FWD, SRC_FWD, $random(seed), $random(seed));
		wait_until_idle(400);
		compare_count("results in test_out_of_order", arrival.size(), 4);
		if (arrival.size() == 4 && arrival[3] != div_rob) begin
			$display("DIV result for rob %0d did not arrive after the MUL results", div_rob);
			errors++;
		end
		finish_test("test_out_of_order", e0);
	endtask

	task automatic test_wb_backpressure();
		int e0;
		int n;
		int s0;
		int r0;
		bit ok;
		e0 = errors;
		n = 0;
		ok = 1'b1;
		s0 = wb_seen;
		r0 = credits_returned;
		set_credit_hold(1'b1);
		// keep issuing until the issue credits dry up
		while (ok && n < 12) begin
			wait_issue_credit(80, ok);
			if (ok) begin
				issue_op(MUL, SRC_FWD, SRC_FWD, $random(seed), $random(seed));
				n++;
			end
		end
		compare_count("micro-ops accepted under back-pressure", n, 2 * WB_BUF_DEPTH + 1);
		compare_count("wb_valid pulses under back-pressure", wb_seen - s0, WB_BUF_DEPTH);
		compare_count("issue credits under back-pressure", credits_returned - r0, n - 1);
		set_credit_hold(1'b0);
		wait_until_idle(400);
		compare_count("wb_valid pulses after release", wb_seen - s0, n);
		finish_test("test_wb_backpressure", e0);
	endtask

	task automatic test_credit_accounting();
		int e0;
		int k;
		int t;
		int i0;
		int r0;
		int s0;
		src_e a_src;
		src_e b_src;
		e0 = errors;
		i0 = issued;
		r0 = credits_returned;
		s0 = wb_seen;
		for (k = 0; k < 8; k++) begin
			a_src = ($random(seed) & 1) ? SRC_FWD : SRC_READ;
			b_src = ($random(seed) & 1) ? SRC_FWD : SRC_READ;
			issue_op(mdu_op_e'(3'(k)), a_src, b_src, $random(seed), $random(seed));
		end
		wait_until_idle(800);
		compare_count("issue credits returned", credits_returned - r0, issued - i0);
		compare_count("wb_valid pulses", wb_seen - s0, issued - i0);
		// pool refilled by the returned credits
		set_credit_hold(1'b1);
		s0 = wb_seen;
		for (k = 0; k <= WB_BUF_DEPTH; k++)
			issue_op(MUL, SRC_FWD, SRC_FWD, $random(seed), $random(seed));
		// one pulse too many means a credit was never spent
		for (t = 0; t < 80 && wb_seen - s0 <= WB_BUF_DEPTH; t++)
			@(posedge CLK);
		compare_count("wb_valid pulses on a refilled credit pool", wb_seen - s0, WB_BUF_DEPTH);
		set_credit_hold(1'b0);
		wait_until_idle(400);
		finish_test("test_credit_accounting", e0);
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------

	initial begin
		nRST = 1'b0;
		issue_valid = 1'b0;
		issue = '0;
		forward_data_by_bank = '0;
		a_reg_read_ack = 1'b0;
		a_reg_read_port = 1'b0;
		b_reg_read_ack = 1'b0;
		b_reg_read_port = 1'b0;
		reg_read_data_by_bank_by_port = '0;
		repeat (8) @(negedge CLK);
		nRST = 1'b1;

		test_mul_ops();
		test_div_ops();
		test_operand_sources();
		test_out_of_order();
		test_wb_backpressure();
		test_credit_accounting();

		$display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: files.f
rtl/mdu_pkg.sv
rtl/core_types_pkg.sv
rtl/mdu_operand_collect.sv
rtl/mdu_multiplier.sv
rtl/mdu_divider.sv
rtl/mdu_writeback.sv
rtl/mdu_pipeline.sv
rtl/mdu_pipeline_wrapper.sv
dv/mdu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the MDU testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module mdu_tb \
	-f files.f -Mdir obj_dir -o mdu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/mdu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
